//--- huff_params.svh
// widths of tokens, coefficients, codes and lengths
// input FIFO depth and Huffman table address width
// fixed in-table addresses of the ZRL and EOB codes
`ifndef HUFF_PARAMS_SVH
`define HUFF_PARAMS_SVH

`define HUFF_FIFO_AW  4      // 16-deep token FIFO
`define HUFF_TOKEN_W  16     // run-length prepared token
`define HUFF_VAL_W    12     // signed coefficient
`define HUFF_CODE_W   16     // right-aligned code bits
`define HUFF_LEN_W    4      // 0 stands for 16
`define HUFF_TAB_AW   9      // color bit + 8-bit symbol

`define HUFF_ZRL_ADDR 8'hf0  // sixteen zeros
`define HUFF_EOB_ADDR 8'h00  // end of block
`define HUFF_DC_COL   4'hf   // DC codes live in the spare AC column

`endif

//--- huff_pkg.sv
// shared types of the Huffman encoder
// vector typedefs for tokens, values, codes and table addresses
// table entry, table write and output word structs
// token kind enum
`include "huff_params.svh"

package huff_pkg;

    typedef logic [`HUFF_TOKEN_W-1:0]       token_t;     // raw FIFO token
    typedef logic signed [`HUFF_VAL_W-1:0]  coef_val_t;  // DC/AC value
    typedef logic [3:0]                     vl_cat_t;    // magnitude category
    typedef logic [3:0]                     run_t;       // zeros before an AC
    typedef logic [`HUFF_CODE_W-1:0]        hcode_t;     // code, right-aligned
    typedef logic [`HUFF_LEN_W-1:0]         hlen_t;      // 0 means 16 bits
    typedef logic [`HUFF_TAB_AW-1:0]        htab_addr_t; // {color, symbol}

    typedef struct packed {
        hlen_t  hlen;   // code length
        hcode_t hcode;  // code bits
    } htab_entry_t;

    typedef struct packed {
        logic        we;     // one-cycle write strobe
        htab_addr_t  addr;
        htab_entry_t entry;
    } table_wr_t;

    typedef struct packed {
        hcode_t bits;   // bits to send
        hlen_t  len;    // how many of them
    } out_word_t;

    // TOK_RLL also tags a ZRL slot inside the step pipeline
    typedef enum logic [1:0] {
        TOK_DC,
        TOK_AC,
        TOK_RLL,
        TOK_EOB
    } tok_kind_e;

endpackage

//--- huff_fifo.sv
// input token FIFO, 16 entries
// circular buffer with read/write pointers and an entry count
// head token shown combinationally, data-available and full flags
`include "huff_params.svh"

module huff_fifo import huff_pkg::*; (
    input  logic   xclk2x_i,
    input  logic   reset_i,
    input  logic   ds_i,      // token strobe from producer
    input  token_t token_i,
    input  logic   rd_i,      // pop head token
    output token_t tok_o,     // oldest entry
    output logic   dav_o,     // not empty
    output logic   full_o
);
    token_t                  mem [0:(1 << `HUFF_FIFO_AW)-1];
    logic [`HUFF_FIFO_AW-1:0] wr_ptr;
    logic [`HUFF_FIFO_AW-1:0] rd_ptr;
    logic [`HUFF_FIFO_AW:0]   count;   // 0..16
    logic                    wr_en;
    logic                    rd_en;

    assign wr_en  = ds_i && !full_o;  // strobes into a full FIFO are lost
    assign rd_en  = rd_i && dav_o;
    assign tok_o  = mem[rd_ptr];
    assign dav_o  = |count;
    assign full_o = count[`HUFF_FIFO_AW]; // msb only set at 16

    always_ff @(posedge xclk2x_i) begin
        if (wr_en) mem[wr_ptr] <= token_i;
    end

    always_ff @(posedge xclk2x_i) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            if (wr_en && !rd_en)      count <= count + 1'b1;
            else if (!wr_en && rd_en) count <= count - 1'b1;
        end
    end

endmodule

//--- huff_sequencer.sv
// token decoder and step pipeline of the encoder
// ZRL counter, run and color registers
// table address from category, run and color
// output source selects, last-block and flush control
`include "huff_params.svh"

module huff_sequencer import huff_pkg::*; (
    input  logic       xclk2x_i,
    input  logic       reset_i,
    input  logic       rdy_i,        // receiver ready, freezes everything when low
    input  token_t     fifo_tok_i,
    input  logic       fifo_dav_i,
    output logic       fifo_rd_o,
    output logic       vl_start_o,
    output coef_val_t  vl_val_o,
    input  vl_cat_t    vl_cat_i,     // valid at steps[1]
    output htab_addr_t taddr_o,
    output logic       sel_code_o,   // table entry next stage
    output logic       sel_bits_o,   // magnitude bits next stage
    output logic       last_block_o,
    output logic       flush_o
);
    tok_kind_e  head_kind;
    logic       head_last_block;
    logic       head_last_word;
    logic [1:0] head_zrl;
    logic [3:0] steps;           // slot position, [3] only for bits words
    logic [1:0] zrl_cnt;         // ZRL codes still to issue
    run_t       run;
    logic       color;           // color of last DC
    logic       single0;
    logic       zrl_issue;
    logic       pop;
    logic       issue;
    logic       idle;
    logic       fire;
    logic       ready_to_flush;  // last word of last block popped
    tok_kind_e  kind0;
    tok_kind_e  kind1;
    run_t       run0;
    run_t       run1;
    logic       color0;
    logic       color1;
    coef_val_t  sval;
    logic       has_bits2;
    logic [7:0] sym;

    always_comb begin
        if (fifo_tok_i[15]) head_kind = fifo_tok_i[14] ? TOK_DC : TOK_AC;
        else                head_kind = fifo_tok_i[12] ? TOK_EOB : TOK_RLL;
    end
    assign head_last_block = fifo_tok_i[15] && fifo_tok_i[14] && fifo_tok_i[12];
    assign head_last_word  = !fifo_tok_i[14] && fifo_tok_i[12]; // AC or EOB with last flag
    assign head_zrl        = fifo_tok_i[5:4];

    // DC/AC slots give two words, so the next slot waits a cycle
    assign single0   = steps[0] && (kind0 == TOK_RLL || kind0 == TOK_EOB);
    assign zrl_issue = (zrl_cnt != 2'b00);
    assign pop       = rdy_i && fifo_dav_i && !zrl_issue && (!steps[0] || single0);
    assign issue     = zrl_issue || (pop && (head_kind != TOK_RLL || head_zrl != 2'b00));
    assign fifo_rd_o = pop;

    assign vl_start_o = steps[0] && (kind0 == TOK_DC || kind0 == TOK_AC);
    assign vl_val_o   = sval;
    assign sel_code_o = steps[1];              // every slot has a code
    assign sel_bits_o = steps[2] && has_bits2;

    always_comb begin
        case (kind1)
            TOK_DC:  sym = {vl_cat_i, `HUFF_DC_COL};
            TOK_AC:  sym = {run1, vl_cat_i};
            TOK_RLL: sym = `HUFF_ZRL_ADDR;
            default: sym = `HUFF_EOB_ADDR;
        endcase
    end
    assign taddr_o = {color1, sym};

    assign idle = (steps == 4'b0000) && !zrl_issue;
    assign fire = ready_to_flush && idle;  // last word leaves the output register

    always_ff @(posedge xclk2x_i) begin
        if (reset_i) begin
            steps          <= '0;
            zrl_cnt        <= '0;
            run            <= '0;
            color          <= 1'b0;
            last_block_o   <= 1'b0;
            ready_to_flush <= 1'b0;
            flush_o        <= 1'b0;
        end else if (rdy_i) begin
            steps <= {sel_bits_o, steps[1:0], issue};
            if (zrl_issue) zrl_cnt <= zrl_cnt - 1'b1;
            else if (pop && head_kind == TOK_RLL && head_zrl != 2'b00) zrl_cnt <= head_zrl - 1'b1;
            if (pop && head_kind == TOK_RLL) run <= fifo_tok_i[3:0];
            else if (pop)                    run <= '0;  // consumed by AC
            if (pop && head_kind == TOK_DC) color <= fifo_tok_i[13];
            flush_o <= fire;
            if (fire) begin
                last_block_o   <= 1'b0;
                ready_to_flush <= 1'b0;
            end else begin
                if (pop && head_last_block) last_block_o <= 1'b1;
                if (pop && last_block_o && head_last_word) ready_to_flush <= 1'b1;
            end
        end
    end

    // slot payload travels with steps
    always_ff @(posedge xclk2x_i) begin
        if (rdy_i) begin
            if (issue) begin
                kind0  <= zrl_issue ? TOK_RLL : head_kind;
                run0   <= run;
                color0 <= (pop && head_kind == TOK_DC) ? fifo_tok_i[13] : color;
            end
            if (pop) sval <= coef_val_t'(fifo_tok_i[11:0]);
            kind1     <= kind0;
            run1      <= run0;
            color1    <= color0;
            has_bits2 <= (kind1 == TOK_DC || kind1 == TOK_AC) && (vl_cat_i != 4'h0);
        end
    end

endmodule

//--- varlen_encode.sv
// magnitude category and extra bits of a signed coefficient
// stage 1 registers category and adjusted value on start
// stage 2 registers the masked bits with their length
`include "huff_params.svh"

module varlen_encode import huff_pkg::*; (
    input  logic      xclk2x_i,
    input  logic      reset_i,
    input  logic      en_i,     // pipeline advance
    input  logic      start_i,  // new DC/AC value
    input  coef_val_t val_i,
    output vl_cat_t   cat_o,    // one stage after start
    output out_word_t bits_o    // two stages after start
);
    logic [`HUFF_VAL_W-1:0] abs_val;
    logic [`HUFF_VAL_W-1:0] mag_next;
    logic [`HUFF_VAL_W-1:0] mag_r;
    logic [`HUFF_VAL_W-1:0] mask;
    vl_cat_t                cat_r;
    logic                   start_d;

    // index of highest set bit plus one
    function automatic vl_cat_t bit_count(input logic [`HUFF_VAL_W-1:0] a);
        vl_cat_t c;
        c = '0;
        for (int i = 0; i < `HUFF_VAL_W; i++) begin
            if (a[i]) c = vl_cat_t'(i + 1);
        end
        return c;
    endfunction

    assign abs_val  = val_i[`HUFF_VAL_W-1] ? ~val_i + 1'b1 : val_i;
    assign mag_next = val_i[`HUFF_VAL_W-1] ? val_i - 1'b1 : val_i;  // one's complement style
    assign mask     = ~({`HUFF_VAL_W{1'b1}} << cat_r);
    assign cat_o    = cat_r;

    always_ff @(posedge xclk2x_i) begin
        if (reset_i)   start_d <= 1'b0;
        else if (en_i) start_d <= start_i;
    end

    always_ff @(posedge xclk2x_i) begin
        if (en_i) begin
            if (start_i) begin
                cat_r <= bit_count(abs_val);
                mag_r <= mag_next;
            end
            if (start_d) begin
                bits_o.bits <= hcode_t'(mag_r & mask);  // keep low cat bits
                bits_o.len  <= cat_r;
            end
        end
    end

endmodule

//--- huff_table.sv
// Huffman code table, 512 entries of length and code
// write port on the pipeline clock
// read register that holds while the pipeline is frozen
`include "huff_params.svh"

module huff_table import huff_pkg::*; (
    input  logic        xclk2x_i,
    input  table_wr_t   table_wr_i,  // direct table load
    input  logic        en_i,        // read enable, follows rdy
    input  htab_addr_t  raddr_i,     // {color, symbol}
    output htab_entry_t entry_o      // next enabled cycle
);
    htab_entry_t mem [0:(1 << `HUFF_TAB_AW)-1];

    always_ff @(posedge xclk2x_i) begin
        if (table_wr_i.we) mem[table_wr_i.addr] <= table_wr_i.entry;
    end

    // Y table in the lower half, CbCr in the upper
    always_ff @(posedge xclk2x_i) begin
        if (en_i) entry_o <= mem[raddr_i];
    end

endmodule

//--- huff_output.sv
// output word register of the encoder
// selects registered one stage ahead of their data
// word held while the receiver is not ready
module huff_output import huff_pkg::*; (
    input  logic        xclk2x_i,
    input  logic        reset_i,
    input  logic        rdy_i,
    input  logic        sel_code_i,  // entry_i valid next cycle
    input  logic        sel_bits_i,  // bits_i valid next cycle
    input  htab_entry_t entry_i,
    input  out_word_t   bits_i,
    output logic        dv_o,
    output hcode_t      data_o,
    output hlen_t       len_o        // 0 means 16
);
    logic sel_code_r;
    logic sel_bits_r;

    always_ff @(posedge xclk2x_i) begin
        if (reset_i) begin
            sel_code_r <= 1'b0;
            sel_bits_r <= 1'b0;
            dv_o       <= 1'b0;
        end else if (rdy_i) begin
            sel_code_r <= sel_code_i;
            sel_bits_r <= sel_bits_i;
            dv_o       <= sel_code_r || sel_bits_r;
        end
    end

    always_ff @(posedge xclk2x_i) begin
        if (rdy_i) begin
            if (sel_bits_r) begin         // never together with a code
                data_o <= bits_i.bits;
                len_o  <= bits_i.len;
            end else if (sel_code_r) begin
                data_o <= entry_i.hcode;
                len_o  <= entry_i.hlen;
            end
        end
    end

endmodule

//--- huffman_encoder.sv
// top of the JPEG Huffman entropy encoder
// token FIFO, sequencer, magnitude encoder, code table, output register
module huffman_encoder import huff_pkg::*; (
    input  logic      xclk2x_i,
    input  logic      reset_i,
    input  logic      ds_i,          // token strobe
    input  token_t    token_i,
    output logic      fifo_full_o,   // producer must hold off
    input  table_wr_t table_wr_i,
    input  logic      rdy_i,         // receiver ready level
    output logic      dv_o,
    output hcode_t    data_o,
    output hlen_t     len_o,
    output logic      last_block_o,
    output logic      flush_o        // after last word of last block
);
    token_t      fifo_tok;
    logic        fifo_dav;
    logic        fifo_rd;
    logic        vl_start;
    coef_val_t   vl_val;
    vl_cat_t     vl_cat;
    out_word_t   vl_bits;
    htab_addr_t  taddr;
    htab_entry_t tab_entry;
    logic        sel_code;
    logic        sel_bits;

    huff_fifo u_fifo (
        .xclk2x_i (xclk2x_i),
        .reset_i  (reset_i),
        .ds_i     (ds_i),
        .token_i  (token_i),
        .rd_i     (fifo_rd),
        .tok_o    (fifo_tok),
        .dav_o    (fifo_dav),
        .full_o   (fifo_full_o)
    );

    huff_sequencer u_seq (
        .xclk2x_i     (xclk2x_i),
        .reset_i      (reset_i),
        .rdy_i        (rdy_i),
        .fifo_tok_i   (fifo_tok),
        .fifo_dav_i   (fifo_dav),
        .fifo_rd_o    (fifo_rd),
        .vl_start_o   (vl_start),
        .vl_val_o     (vl_val),
        .vl_cat_i     (vl_cat),
        .taddr_o      (taddr),
        .sel_code_o   (sel_code),
        .sel_bits_o   (sel_bits),
        .last_block_o (last_block_o),
        .flush_o      (flush_o)
    );

    varlen_encode u_varlen (
        .xclk2x_i (xclk2x_i),
        .reset_i  (reset_i),
        .en_i     (rdy_i),
        .start_i  (vl_start),
        .val_i    (vl_val),
        .cat_o    (vl_cat),
        .bits_o   (vl_bits)
    );

    huff_table u_table (
        .xclk2x_i   (xclk2x_i),
        .table_wr_i (table_wr_i),
        .en_i       (rdy_i),
        .raddr_i    (taddr),
        .entry_o    (tab_entry)
    );

    huff_output u_out (
        .xclk2x_i   (xclk2x_i),
        .reset_i    (reset_i),
        .rdy_i      (rdy_i),
        .sel_code_i (sel_code),
        .sel_bits_i (sel_bits),
        .entry_i    (tab_entry),
        .bits_i     (vl_bits),
        .dv_o       (dv_o),
        .data_o     (data_o),
        .len_o      (len_o)
    );

endmodule

//--- tb_huffman.sv
// testbench of the Huffman encoder top level
// random blocks of DC, RLL, AC and EOB tokens checked against a reference model
// random receiver back-pressure, output hold, last-block and flush checks
// FIFO full flag while the receiver is stalled
`include "huff_params.svh"

module tb_huffman import huff_pkg::*; ();
    logic        clk;
    logic        reset;
    logic        ds;
    token_t      token;
    logic        fifo_full;
    table_wr_t   table_wr;
    logic        rdy;
    logic        dv;
    hcode_t      data;
    hlen_t       len;
    logic        last_block;
    logic        flush;

    integer      seed;
    integer      errors;
    integer      tests_passed;
    integer      tests_failed;
    integer      cycle_cnt;
    integer      cycle_limit;   // raised per test from its token count
    integer      taken;         // words taken in the running test
    integer      last_dc_idx;   // index of the last-block DC code word
    integer      flush_cnt;
    logic        bp_on;
    logic        hold_prev;     // word was offered but not taken
    hcode_t      data_prev;
    hlen_t       len_prev;
    out_word_t   exp_w;
    htab_entry_t tab_model [0:(1 << `HUFF_TAB_AW)-1];
    out_word_t   exp_q [$];     // expected words in order
    token_t      tok_q [$];     // tokens still to send
    run_t        model_run;
    logic        model_color;

    huffman_encoder uut (
        .xclk2x_i     (clk),
        .reset_i      (reset),
        .ds_i         (ds),
        .token_i      (token),
        .fifo_full_o  (fifo_full),
        .table_wr_i   (table_wr),
        .rdy_i        (rdy),
        .dv_o         (dv),
        .data_o       (data),
        .len_o        (len),
        .last_block_o (last_block),
        .flush_o      (flush)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles, %0d words still expected", cycle_cnt,
                     exp_q.size());
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // bit count of the absolute value
    function automatic vl_cat_t mag_category(input integer v);
        integer  a;
        vl_cat_t c;
        a = (v < 0) ? -v : v;
        c = '0;
        while (a > 0) begin
            a = a / 2;
            c = c + 1'b1;
        end
        return c;
    endfunction

    // value itself, or value minus one when negative, cut to the category
    function automatic out_word_t extra_bits(input integer v);
        integer    m;
        vl_cat_t   c;
        out_word_t w;
        c = mag_category(v);
        m = (v < 0) ? v - 1 : v;
        w.bits = hcode_t'(m & ((1 << c) - 1));
        w.len  = c;
        return w;
    endfunction

    task automatic expect_code(input logic [7:0] sym);
        htab_entry_t e;
        out_word_t   w;
        e = tab_model[{model_color, sym}];  // color of the latest DC
        w.bits = e.hcode;
        w.len  = e.hlen;
        exp_q.push_back(w);
    endtask

    task automatic model_token(input token_t t);
        integer  v;
        vl_cat_t c;
        v = $signed(t[11:0]);
        c = mag_category(v);
        if (t[15]) begin
            if (t[14]) begin                  // DC
                model_color = t[13];
                expect_code({c, `HUFF_DC_COL});
            end else begin                    // AC
                expect_code({model_run, c});
            end
            if (c != 0) exp_q.push_back(extra_bits(v));
            model_run = '0;
        end else if (!t[12]) begin            // RLL
            repeat (t[5:4]) expect_code(`HUFF_ZRL_ADDR);
            model_run = t[3:0];
        end else begin                        // EOB
            expect_code(`HUFF_EOB_ADDR);
            model_run = '0;
        end
    endtask

    task automatic add_token(input token_t t);
        tok_q.push_back(t);
        model_token(t);
    endtask

    task automatic random_value(output integer v);
        integer sh;
        sh = $unsigned($random(seed)) % 11;       // spread over the categories
        v  = ($random(seed) % 2048) / (1 << sh);
    endtask

    task automatic make_block(input logic last);
        integer v;
        integer n;
        integer i;
        random_value(v);
        if ($unsigned($random(seed)) % 8 == 0) v = 0;  // some DCs without bits
        if (last) last_dc_idx = exp_q.size();
        add_token({2'b11, 1'($random(seed)), last, 12'(v)});
        n = $unsigned($random(seed)) % 9;
        for (i = 0; i < n; i++) begin
            if ($random(seed) & 1) begin
                add_token({4'b0000, 6'd0, 2'($random(seed)), 4'($random(seed))});
            end else begin
                random_value(v);
                if (v == 0) v = 1;
                add_token({4'b1000, 12'(v)});
            end
        end
        add_token(16'h1000);                  // EOB, also the last word flag
    endtask

    // one clock, then receiver level and at most one token strobe
    task automatic step_cycle();
        @(posedge clk);
        #1;
        rdy = bp_on ? ($unsigned($random(seed)) % 10 >= 3) : 1'b1;
        ds  = 1'b0;
        if (tok_q.size() > 0 && !fifo_full && $unsigned($random(seed)) % 5 != 0) begin
            ds    = 1'b1;
            token = tok_q.pop_front();
        end
    endtask

    // receiver stalled, so nothing is popped and the FIFO only fills
    task automatic fill_fifo();
        integer i;
        integer sent;
        sent = 0;
        for (i = 0; i <= (1 << `HUFF_FIFO_AW); i++) begin
            @(posedge clk);
            #1;
            rdy = 1'b0;
            ds  = 1'b0;
            assert (fifo_full == (sent == (1 << `HUFF_FIFO_AW))) else begin
                $display("Mismatch at %0t: fifo_full_o expected %b, got %b", $time,
                         sent == (1 << `HUFF_FIFO_AW), fifo_full);
                errors++;
            end
            if (i < (1 << `HUFF_FIFO_AW) && tok_q.size() > 0) begin
                ds    = 1'b1;
                token = tok_q.pop_front();
                sent++;
            end
        end
    endtask

    task automatic run_test(input string name, input logic bp, input integer nblocks);
        integer b;
        integer err0;
        err0      = errors;
        taken     = 0;
        flush_cnt = 0;
        for (b = 0; b < nblocks; b++) make_block(b == nblocks - 1);
        cycle_limit = cycle_cnt + tok_q.size() * 64 * 4 + 64;
        fill_fifo();
        bp_on = bp;
        while (tok_q.size() > 0 || exp_q.size() > 0 || flush_cnt == 0) step_cycle();
        repeat (8) step_cycle();              // room for a second flush pulse
        bp_on = 1'b0;
        step_cycle();
        assert (flush_cnt == 1) else begin
            $display("flush_o pulsed %0d times in test %s instead of once", flush_cnt, name);
            errors++;
        end
        assert (!last_block) else begin
            $display("last_block_o still high after flush_o in test %s", name);
            errors++;
        end
        if (errors == err0) tests_passed++;
        else                tests_failed++;
        $display("test %s: %0d words, %0d errors", name, taken, errors - err0);
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (hold_prev) begin
                assert (data == data_prev) else begin
                    $display("Mismatch at %0t: data_o expected %h (held), got %h", $time,
                             data_prev, data);
                    errors++;
                end
                assert (len == len_prev) else begin
                    $display("Mismatch at %0t: len_o expected %h (held), got %h", $time,
                             len_prev, len);
                    errors++;
                end
            end
            if (dv && rdy) begin
                assert (exp_q.size() > 0) else begin
                    $display("%0t: output word taken while no word was expected", $time);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    exp_w = exp_q.pop_front();
                    assert (data == exp_w.bits) else begin
                        $display("Mismatch at %0t: data_o expected %h, got %h", $time,
                                 exp_w.bits, data);
                        errors++;
                    end
                    assert (len == exp_w.len) else begin
                        $display("Mismatch at %0t: len_o expected %h, got %h", $time,
                                 exp_w.len, len);
                        errors++;
                    end
                end
                if (taken >= last_dc_idx) begin
                    assert (last_block) else begin
                        $display("%0t: last_block_o low at word %0d of the last block", $time,
                                 taken);
                        errors++;
                    end
                end
                taken++;
            end
            if (flush && rdy) begin
                assert (exp_q.size() == 0 && tok_q.size() == 0 && taken > last_dc_idx)
                else begin
                    $display("%0t: flush_o pulsed before the last block was done, %0d words left",
                             $time, exp_q.size());
                    errors++;
                end
                flush_cnt++;
            end
            hold_prev = dv && !rdy;
            data_prev = data;
            len_prev  = len;
        end
    end

    initial begin
        integer a;
        seed         = 32'h5179;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_cnt    = 0;
        cycle_limit  = 1024;                  // reset and table load
        last_dc_idx  = 1 << 30;
        taken        = 0;
        flush_cnt    = 0;
        reset        = 1'b1;
        ds           = 1'b0;
        token        = '0;
        table_wr     = '0;
        rdy          = 1'b1;
        bp_on        = 1'b0;
        hold_prev    = 1'b0;
        model_run    = '0;
        model_color  = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        for (a = 0; a < (1 << `HUFF_TAB_AW); a++) begin
            table_wr.we          = 1'b1;
            table_wr.addr        = htab_addr_t'(a);
            table_wr.entry.hlen  = hlen_t'($random(seed));
            table_wr.entry.hcode = hcode_t'($random(seed));
            tab_model[a]         = table_wr.entry;
            @(posedge clk);
            #1;
        end
        table_wr = '0;
        run_test("steady receiver", 1'b0, 6);
        run_test("back-pressure", 1'b1, 10);
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+.
huff_pkg.sv
huff_fifo.sv
huff_sequencer.sv
varlen_encode.sv
huff_table.sv
huff_output.sv
huffman_encoder.sv
tb_huffman.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the Huffman encoder testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f all.f \
        --top-module tb_huffman -o tb_huffman; then
    echo "build failed"
    exit 1
fi

out="$(./obj_dir/tb_huffman)"
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^PASS: all tests$"; then
    exit 0
fi
exit 1
